//--- filelist.f
+incdir+tests
hdl/trace_pkg.sv
hdl/event_fifo.sv
hdl/rr_arbiter.sv
hdl/trace_buffer.sv
hdl/burst_reader.sv
hdl/trace_logger.sv
tests/tb_trace_logger.sv

//--- Makefile
TOP = tb_trace_logger

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module trace_logger
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_trace_tasks.svh
// entry field helpers, compare tasks, stimulus and read tasks, directed tests

function automatic logic [SB-1:0] src_of(input logic [ENTRY_W-1:0] e);
   return e[ENTRY_W-1 -: SB];
endfunction

function automatic logic [EW-1:0] ev_of(input logic [ENTRY_W-1:0] e);
   return e[2*SW +: EW];
endfunction

function automatic trace_pkg::stamp_t cyc_of(input logic [ENTRY_W-1:0] e);
   return e[SW +: SW];
endfunction

function automatic trace_pkg::stamp_t seq_of(input logic [ENTRY_W-1:0] e);
   return e[0 +: SW];
endfunction

task automatic check_bit(input string what, input logic exp, input logic act);
   if (act !== exp) begin
      $display("FAIL %s: %s expected %0b actual %0b", cur_test, what, exp, act);
      stop_run();
   end
endtask

task automatic check_stamp(input string what, input trace_pkg::stamp_t exp,
                           input trace_pkg::stamp_t act);
   if (act !== exp) begin
      $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      stop_run();
   end
endtask

task automatic check_event(input string what, input logic [SB-1:0] src,
                           input logic [EW-1:0] ev, input logic [ENTRY_W-1:0] act);
   if (src_of(act) !== src || ev_of(act) !== ev) begin
      $display("FAIL %s: %s expected src %0d event %h actual src %0d event %h",
               cur_test, what, src, ev, src_of(act), ev_of(act));
      stop_run();
   end
endtask

task automatic check_entry(input string what, input logic [SB-1:0] src,
                           input logic [EW-1:0] ev, input trace_pkg::stamp_t cyc,
                           input trace_pkg::stamp_t seq, input logic [ENTRY_W-1:0] act);
   if (act !== {src, ev, cyc, seq}) begin
      $display("FAIL %s: %s (src/event/cycle/seq) expected %0d/%h/%0d/%0d actual %0d/%h/%0d/%0d",
               cur_test, what, src, ev, cyc, seq,
               src_of(act), ev_of(act), cyc_of(act), seq_of(act));
      stop_run();
   end
endtask

// strobe the masked sources for a number of cycles with random payloads
task automatic drive_events(input logic [NSRC-1:0] mask, input int ncyc);
   for (int c = 0; c < ncyc; c++) begin
      for (int s = 0; s < NSRC; s++) begin
         pay[c*NSRC + s] = EW'($random(seed));
         ev_data[s*EW +: EW] = pay[c*NSRC + s];
         if (mask[s] && !ev_full[s]) begin
            logged++;
         end
         if (ev_full[s]) begin
            full_seen = 1'b1;
         end
      end
      ev_valid = mask;
      @(posedge clk);
      #1;
   end
   ev_valid = '0;
endtask

// until every source FIFO has been granted empty
task automatic wait_drained();
   int busy;
   busy = 1;
   while (busy != 0) begin
      busy = 0;
      for (int s = 0; s < NSRC; s++) begin
         busy += fcnt[s];
      end
      if (busy != 0) begin
         @(posedge clk);
         #1;
      end
   end
endtask

// one host burst; optional 3-cycle stall once stall_after beats are done
task automatic read_burst(input int len, input int stall_after);
   logic [ENTRY_W-1:0] held;
   logic               stalled;
   int                 got;
   got = 0;
   stalled = 1'b0;
   rd_req = 1'b1;
   rd_len = trace_pkg::burst_len_t'(len - 1);
   rd_ready = 1'b1;
   @(posedge clk);
   #1;
   rd_req = 1'b0;
   while (got < len) begin
      if (got == stall_after && !stalled) begin
         stalled = 1'b1;
         rd_ready = 1'b0;
         held = rd_data;
         repeat (3) begin
            @(negedge clk);
            check_bit("rd_valid while stalled", 1'b1, rd_valid);
            check_entry("rd_data while stalled", src_of(held), ev_of(held),
                        cyc_of(held), seq_of(held), rd_data);
            @(posedge clk);
            #1;
         end
         rd_ready = 1'b1;
      end
      @(negedge clk);
      if (rd_valid) begin
         check_bit("rd_last", got == len - 1, rd_last);
         cap[got] = rd_data;
         got++;
      end
      @(posedge clk);
      #1;
   end
endtask

// beats from one source: payloads from cycle first on, newest sequence numbers
task automatic check_single(input int n, input int src, input int first);
   for (int i = 0; i < n; i++) begin
      check_event("beat", SB'(src), pay[(first + i)*NSRC + src], cap[i]);
      check_stamp("sequence", trace_pkg::stamp_t'(logged - n + i), seq_of(cap[i]));
   end
endtask

task automatic test_reset();
   cur_test = "after reset";
   check_bit("rd_valid", 1'b0, rd_valid);
   check_bit("rd_last", 1'b0, rd_last);
   for (int s = 0; s < NSRC; s++) begin
      check_bit("ev_full", 1'b0, ev_full[s]);
   end
endtask

task automatic test_single_source();
   cur_test = "single source";
   drive_events(NSRC'(4), 3);
   wait_drained();
   read_burst(3, -1);
   check_single(3, 2, 0);
   for (int i = 1; i < 3; i++) begin
      if (cyc_of(cap[i]) <= cyc_of(cap[i-1])) begin
         $display("%s: cycle stamps do not increase from beat to beat", cur_test);
         stop_run();
      end
   end
endtask

task automatic test_round_robin();
   int src;
   cur_test = "round robin";
   drive_events('1, 2);
   wait_drained();
   read_burst(2*NSRC, -1);
   // source 2 won last, so the order starts at source 3 and wraps
   for (int i = 0; i < 2*NSRC; i++) begin
      src = (3 + i) % NSRC;
      check_event("beat", SB'(src), pay[(i/NSRC)*NSRC + src], cap[i]);
   end
endtask

task automatic test_fifo_full();
   cur_test = "fifo full";
   full_seen = 1'b0;
   drive_events('1, 12);
   check_bit("ev_full seen", 1'b1, full_seen);
   wait_drained();
   read_burst(LDEPTH, -1);
   for (int i = 0; i < LDEPTH; i++) begin
      check_stamp("sequence", trace_pkg::stamp_t'(logged - LDEPTH + i), seq_of(cap[i]));
   end
endtask

task automatic test_overwrite();
   cur_test = "overwrite";
   drive_events(NSRC'(2), 20);
   wait_drained();
   read_burst(LDEPTH, -1);
   // the four oldest entries are gone
   check_single(LDEPTH, 1, 20 - LDEPTH);
endtask

task automatic test_backpressure();
   cur_test = "back-pressure";
   drive_events(NSRC'(8), 4);
   wait_drained();
   read_burst(4, 1);
   check_single(4, 3, 0);
endtask

//--- tests/tb_trace_logger.sv
// trace logger testbench top: clock, reset, DUT, timeout, log reference model, test sequence
`timescale 1ns/1ps

module tb_trace_logger;

   localparam int SB      = trace_pkg::SRC_BITS_DEF;
   localparam int EW      = trace_pkg::EVENT_WIDTH_DEF;
   localparam int NSRC    = 1 << SB;
   localparam int FDEPTH  = 1 << trace_pkg::FIFO_LOG_DEPTH_DEF;
   localparam int LDEPTH  = 1 << trace_pkg::LOG_DEPTH_DEF;
   localparam int SW      = $bits(trace_pkg::stamp_t);
   localparam int ENTRY_W = SB + EW + 2*SW;
   // the test sequence needs roughly 150 cycles
   localparam int MAX_CYCLES = 2000;

   logic                  clk;
   logic                  rstn;
   logic [NSRC-1:0]       ev_valid;
   logic [NSRC*EW-1:0]    ev_data;
   logic [NSRC-1:0]       ev_full;
   logic                  rd_req;
   trace_pkg::burst_len_t rd_len;
   logic                  rd_ready;
   logic                  rd_valid;
   logic                  rd_last;
   logic [ENTRY_W-1:0]    rd_data;

   int    seed = 86592;
   int    cycles = 0;
   string cur_test = "reset";

   // reference model state: per-source FIFOs, log, stamps, burst count
   logic [EW-1:0]     fq [NSRC][FDEPTH];
   int                fcnt [NSRC];
   logic [SB-1:0]     log_src [$];
   logic [EW-1:0]     log_ev [$];
   trace_pkg::stamp_t log_cyc [$];
   trace_pkg::stamp_t log_seq [$];
   trace_pkg::stamp_t cyc_next;
   trace_pkg::stamp_t seq_next;
   int                last_g;
   int                rem;

   // payloads per cycle and source, captured beats, accepted event count
   logic [EW-1:0]      pay [NSRC*20];
   logic [ENTRY_W-1:0] cap [LDEPTH];
   int                 logged = 0;
   logic               full_seen;

   trace_logger i_dut (
      .clk      (clk),
      .rstn     (rstn),
      .ev_valid (ev_valid),
      .ev_data  (ev_data),
      .ev_full  (ev_full),
      .rd_req   (rd_req),
      .rd_len   (rd_len),
      .rd_ready (rd_ready),
      .rd_valid (rd_valid),
      .rd_last  (rd_last),
      .rd_data  (rd_data)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic stop_run();
      $display("Testbench failed");
      $fatal(1, "stopped at the first error");
   endtask

   `include "tb_trace_tasks.svh"

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         stop_run();
      end
   end

   // model steps at mid-cycle, predicting what the next rising edge does
   always @(negedge clk) begin
      logic            exp_valid;
      logic [NSRC-1:0] acc;
      int              g;
      if (!rstn) begin
         for (int s = 0; s < NSRC; s++) begin
            fcnt[s] = 0;
         end
         log_src.delete();
         log_ev.delete();
         log_cyc.delete();
         log_seq.delete();
         cyc_next = '0;
         seq_next = '0;
         last_g = 0;
         rem = 0;
      end else begin
         exp_valid = (rem != 0) && (log_ev.size() != 0);
         check_bit("rd_valid", exp_valid, rd_valid);
         check_bit("rd_last", rem == 1, rd_last);
         for (int s = 0; s < NSRC; s++) begin
            check_bit("ev_full", fcnt[s] == FDEPTH, ev_full[s]);
            acc[s] = ev_valid[s] && (fcnt[s] < FDEPTH);
         end
         if (exp_valid && rd_ready) begin
            check_entry("rd_data", log_src[0], log_ev[0], log_cyc[0], log_seq[0], rd_data);
            void'(log_src.pop_front());
            void'(log_ev.pop_front());
            void'(log_cyc.pop_front());
            void'(log_seq.pop_front());
         end
         if (rd_req) begin
            rem = int'(rd_len) + 1;
         end else if (exp_valid && rd_ready) begin
            rem--;
         end
         // first non-empty source above the last grant, wrapping
         g = -1;
         for (int k = 1; k <= NSRC; k++) begin
            if (g < 0 && fcnt[(last_g + k) % NSRC] > 0) begin
               g = (last_g + k) % NSRC;
            end
         end
         if (g >= 0) begin
            log_src.push_back(SB'(g));
            log_ev.push_back(fq[g][0]);
            log_cyc.push_back(cyc_next);
            log_seq.push_back(seq_next);
            seq_next = seq_next + 1;
            for (int j = 0; j < FDEPTH - 1; j++) begin
               fq[g][j] = fq[g][j+1];
            end
            fcnt[g]--;
            last_g = g;
            // full log drops its oldest entry
            if (log_ev.size() > LDEPTH) begin
               void'(log_src.pop_front());
               void'(log_ev.pop_front());
               void'(log_cyc.pop_front());
               void'(log_seq.pop_front());
            end
         end
         for (int s = 0; s < NSRC; s++) begin
            if (acc[s]) begin
               fq[s][fcnt[s]] = ev_data[s*EW +: EW];
               fcnt[s]++;
            end
         end
         cyc_next = cyc_next + 1;
      end
   end

   initial begin
      rstn = 1'b0;
      ev_valid = '0;
      ev_data = '0;
      rd_req = 1'b0;
      rd_len = '0;
      rd_ready = 1'b1;
      full_seen = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;
      test_reset();
      test_single_source();
      test_round_robin();
      test_fifo_full();
      test_overwrite();
      test_backpressure();
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- hdl/trace_logger.sv
// trace logger top: per-source FIFOs, arbiter, trace buffer and burst reader
`timescale 1ns/1ps

module trace_logger #(
   parameter int SRC_BITS       = trace_pkg::SRC_BITS_DEF,
   parameter int EVENT_WIDTH    = trace_pkg::EVENT_WIDTH_DEF,
   parameter int FIFO_LOG_DEPTH = trace_pkg::FIFO_LOG_DEPTH_DEF,
   parameter int LOG_DEPTH      = trace_pkg::LOG_DEPTH_DEF,
   localparam int NSRC          = 1 << SRC_BITS,
   localparam int ENTRY_W       = SRC_BITS + EVENT_WIDTH + 2*$bits(trace_pkg::stamp_t)
) (
   input  logic                        clk,
   input  logic                        rstn,

   input  logic [NSRC-1:0]             ev_valid,
   input  logic [NSRC*EVENT_WIDTH-1:0] ev_data,
   output logic [NSRC-1:0]             ev_full,

   input  logic                        rd_req,
   input  trace_pkg::burst_len_t       rd_len,
   input  logic                        rd_ready,

   output logic                        rd_valid,
   output logic                        rd_last,
   output logic [ENTRY_W-1:0]          rd_data
);

   logic [NSRC-1:0]        fifo_empty;
   logic [NSRC-1:0]        fifo_pop;
   logic [EVENT_WIDTH-1:0] fifo_head [NSRC];
   logic [SRC_BITS-1:0]    grant;
   logic                   grant_valid;
   logic                   buf_pop;
   logic                   buf_empty;

   for (genvar i = 0; i < NSRC; i++) begin : g_src
      // pop the granted source only
      assign fifo_pop[i] = grant_valid & (grant == SRC_BITS'(i));

      event_fifo #(
         .EVENT_WIDTH    (EVENT_WIDTH),
         .FIFO_LOG_DEPTH (FIFO_LOG_DEPTH)
      ) i_fifo (
         .clk     (clk),
         .rstn    (rstn),
         .wr_en   (ev_valid[i]),
         .wr_data (ev_data[i*EVENT_WIDTH +: EVENT_WIDTH]),
         .rd_en   (fifo_pop[i]),
         .rd_data (fifo_head[i]),
         .full    (ev_full[i]),
         .empty   (fifo_empty[i])
      );
   end

   rr_arbiter #(
      .SRC_BITS (SRC_BITS)
   ) i_arb (
      .clk         (clk),
      .rstn        (rstn),
      .req         (~fifo_empty),
      .grant       (grant),
      .grant_valid (grant_valid)
   );

   // granted head goes into the log in the same cycle it is popped
   trace_buffer #(
      .SRC_BITS    (SRC_BITS),
      .EVENT_WIDTH (EVENT_WIDTH),
      .LOG_DEPTH   (LOG_DEPTH)
   ) i_buf (
      .clk      (clk),
      .rstn     (rstn),
      .wr_en    (grant_valid),
      .wr_src   (grant),
      .wr_event (fifo_head[grant]),
      .pop      (buf_pop),
      .head     (rd_data),
      .empty    (buf_empty)
   );

   burst_reader i_rd (
      .clk       (clk),
      .rstn      (rstn),
      .rd_req    (rd_req),
      .rd_len    (rd_len),
      .rd_ready  (rd_ready),
      .buf_empty (buf_empty),
      .rd_valid  (rd_valid),
      .rd_last   (rd_last),
      .pop       (buf_pop)
   );

endmodule

//--- hdl/burst_reader.sv
// host burst reader: remaining-beat counter, pops and last-beat flag
`timescale 1ns/1ps

module burst_reader (
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  rd_req,
   input  trace_pkg::burst_len_t rd_len,
   input  logic                  rd_ready,

   input  logic                  buf_empty,

   output logic                  rd_valid,
   output logic                  rd_last,
   output logic                  pop
);

   trace_pkg::burst_len_t remaining;
   logic                  beat;

   // beats only flow while the log has something to give
   assign rd_valid = (remaining != '0) & ~buf_empty;
   assign rd_last  = (remaining == trace_pkg::burst_len_t'(1));

   assign beat = rd_valid & rd_ready;
   assign pop  = beat;

   // a new request restarts the count, even mid-burst
   always_ff @(posedge clk) begin
      if (!rstn) begin
         remaining <= '0;
      end else if (rd_req) begin
         remaining <= rd_len + 1'b1;
      end else if (beat) begin
         remaining <= remaining - 1'b1;
      end
   end

endmodule

//--- hdl/trace_buffer.sv
// stamped trace log memory, overwrites the oldest entry when full
`timescale 1ns/1ps

module trace_buffer #(
   parameter int SRC_BITS    = 2,
   parameter int EVENT_WIDTH = 16,
   parameter int LOG_DEPTH   = 4,
   localparam int ENTRY_W    = SRC_BITS + EVENT_WIDTH + 2*$bits(trace_pkg::stamp_t)
) (
   input  logic                   clk,
   input  logic                   rstn,

   input  logic                   wr_en,
   input  logic [SRC_BITS-1:0]    wr_src,
   input  logic [EVENT_WIDTH-1:0] wr_event,

   input  logic                   pop,
   output logic [ENTRY_W-1:0]     head,
   output logic                   empty
);

   localparam int DEPTH = 1 << LOG_DEPTH;

   trace_pkg::stamp_t cycle_cnt;
   trace_pkg::stamp_t seq_cnt;

   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;
   logic [LOG_DEPTH:0] next_rd_ptr;

   logic [ENTRY_W-1:0] mem [DEPTH];
   logic [ENTRY_W-1:0] mem_out;
   logic [ENTRY_W-1:0] wr_entry;
   logic [ENTRY_W-1:0] wr_entry_q;
   logic               collision;
   logic               full;
   logic               rd_adv;

   // free-running cycle count, sequence number counts writes
   always_ff @(posedge clk) begin
      if (!rstn) begin
         cycle_cnt <= '0;
         seq_cnt   <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
         if (wr_en) begin
            seq_cnt <= seq_cnt + 1'b1;
         end
      end
   end

   // source on top, sequence number at the bottom
   assign wr_entry = {wr_src, wr_event, cycle_cnt, seq_cnt};

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]) &
                  (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]);

   // a write into a full log drops the oldest entry;
   // a pop in the same cycle already makes room, so one step is enough
   assign rd_adv = pop | (full & wr_en);

   assign next_rd_ptr = rd_ptr + {{LOG_DEPTH{1'b0}}, rd_adv};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_adv) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // bypass flag for a write to the slot that becomes the head
   always_ff @(posedge clk) begin
      if (!rstn) begin
         collision <= 1'b0;
      end else begin
         collision <= wr_en & (wr_ptr == next_rd_ptr);
      end
   end

   always_ff @(posedge clk) begin
      wr_entry_q <= wr_entry;
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_entry;
      end
      mem_out <= mem[next_rd_ptr[LOG_DEPTH-1:0]];
   end

   // oldest entry, or the one just written if it landed there
   assign head = collision ? wr_entry_q : mem_out;

endmodule

//--- hdl/rr_arbiter.sv
// round-robin arbiter over the non-empty sources, lowest set bit of a doubled vector
`timescale 1ns/1ps

module rr_arbiter #(
   parameter int SRC_BITS = 2
) (
   input  logic                      clk,
   input  logic                      rstn,

   input  logic [(1<<SRC_BITS)-1:0]  req,
   output logic [SRC_BITS-1:0]       grant,
   output logic                      grant_valid
);

   localparam int NSRC = 1 << SRC_BITS;

   logic [SRC_BITS-1:0] last_grant;
   logic [2*NSRC-1:0]   dbl_req;

   // lower half only sees sources above the last grant, upper half sees all
   always_comb begin
      for (int i = 0; i < NSRC; i++) begin
         dbl_req[i]        = req[i] & (SRC_BITS'(i) > last_grant);
         dbl_req[NSRC + i] = req[i];
      end
   end

   // scan from the top so the lowest set bit wins;
   // with a power-of-two source count the fold back into range is a truncation
   always_comb begin
      grant = '0;
      for (int i = 2*NSRC-1; i >= 0; i--) begin
         if (dbl_req[i]) begin
            grant = SRC_BITS'(i);
         end
      end
   end

   assign grant_valid = |req;

   // remember the winner of every valid grant
   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_grant <= '0;
      end else if (grant_valid) begin
         last_grant <= grant;
      end
   end

endmodule

//--- hdl/event_fifo.sv
// first-word-fall-through event FIFO with read-during-write bypass
`timescale 1ns/1ps

module event_fifo #(
   parameter int EVENT_WIDTH    = 16,
   parameter int FIFO_LOG_DEPTH = 2
) (
   input  logic                   clk,
   input  logic                   rstn,

   input  logic                   wr_en,
   input  logic [EVENT_WIDTH-1:0] wr_data,

   input  logic                   rd_en,
   output logic [EVENT_WIDTH-1:0] rd_data,

   output logic                   full,
   output logic                   empty
);

   localparam int DEPTH = 1 << FIFO_LOG_DEPTH;

   // pointers carry one extra wrap bit
   logic [FIFO_LOG_DEPTH:0] wr_ptr;
   logic [FIFO_LOG_DEPTH:0] rd_ptr;
   logic [FIFO_LOG_DEPTH:0] next_rd_ptr;

   logic [EVENT_WIDTH-1:0] mem [DEPTH];
   logic [EVENT_WIDTH-1:0] mem_out;
   logic [EVENT_WIDTH-1:0] wr_data_q;
   logic                   collision;
   logic                   wr_ok;

   // same address, wrap bit decides between empty and full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_LOG_DEPTH-1:0] == rd_ptr[FIFO_LOG_DEPTH-1:0]) &
                  (wr_ptr[FIFO_LOG_DEPTH] != rd_ptr[FIFO_LOG_DEPTH]);

   // a strobe into a full FIFO is dropped
   assign wr_ok = wr_en & ~full;

   assign next_rd_ptr = rd_ptr + {{FIFO_LOG_DEPTH{1'b0}}, rd_en};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // write landing on the slot fetched next, so the memory read is stale
   always_ff @(posedge clk) begin
      if (!rstn) begin
         collision <= 1'b0;
      end else begin
         collision <= wr_ok & (wr_ptr == next_rd_ptr);
      end
   end

   always_ff @(posedge clk) begin
      wr_data_q <= wr_data;
   end

   // head is prefetched from the pointer after this cycle's pop
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr[FIFO_LOG_DEPTH-1:0]] <= wr_data;
      end
      mem_out <= mem[next_rd_ptr[FIFO_LOG_DEPTH-1:0]];
   end

   assign rd_data = collision ? wr_data_q : mem_out;

endmodule

//--- hdl/trace_pkg.sv
// trace logger package: default sizes, stamp type and burst length type
package trace_pkg;

   // source index width, four sources by default
   localparam int SRC_BITS_DEF = 2;

   // event payload width
   localparam int EVENT_WIDTH_DEF = 16;

   // per-source FIFO depth as a power of two, four entries
   localparam int FIFO_LOG_DEPTH_DEF = 2;

   // trace buffer depth as a power of two, sixteen entries
   localparam int LOG_DEPTH_DEF = 4;

   // one stamp word, used for both the cycle count and the sequence number
   typedef logic [31:0] stamp_t;

   // host burst length minus one, also the remaining-beat count
   typedef logic [7:0] burst_len_t;

endpackage
